// File: verilog/opm_pkg.sv
package opm_pkg;

    //////////////////////////////
    // widths

    typedef logic [7:0] bus_data_t;     // one byte on the cpu bus
    typedef logic [7:0] reg_addr_t;
    typedef logic [4:0] slot_t;         // slot index in a frame
    typedef logic [9:0] timer_a_t;
    typedef logic [7:0] timer_b_t;
    typedef logic [5:0] busy_cnt_t;

    //////////////////////////////
    // timing

    localparam int SLOTS_PER_FRAME  = 32;
    localparam int TIMER_B_PRESCALE = 16;   // frames per timer b step
    localparam int BUSY_CYCLES      = 32;   // clocks of busy after a data write

    //////////////////////////////
    // register map

    localparam reg_addr_t ADDR_CLKA1      = 8'h10;  // timer a bits 9:2
    localparam reg_addr_t ADDR_CLKA2      = 8'h11;  // timer a bits 1:0
    localparam reg_addr_t ADDR_CLKB       = 8'h12;
    localparam reg_addr_t ADDR_TIMER_CTRL = 8'h14;
    localparam reg_addr_t ADDR_CT         = 8'h1B;  // bit 7 ct2, bit 6 ct1

    // control register bits
    localparam int CTRL_LOAD_A  = 0;
    localparam int CTRL_LOAD_B  = 1;
    localparam int CTRL_IRQEN_A = 2;
    localparam int CTRL_IRQEN_B = 3;
    localparam int CTRL_FRST_A  = 4;
    localparam int CTRL_FRST_B  = 5;

    // status byte bits
    localparam int STAT_FLAG_A = 0;
    localparam int STAT_FLAG_B = 1;
    localparam int STAT_BUSY   = 7;

endpackage

// File: verilog/opm_timing.sv
module opm_timing
    import opm_pkg::*;
(
    input  logic i_emuclk,
    input  logic i_rst_n,

    output logic o_frame_end
);

    slot_t slot_cnt;    // current slot, 0..31
    logic  last_slot;

    assign last_slot = (slot_cnt == slot_t'(SLOTS_PER_FRAME - 1));

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            slot_cnt <= '0;
        end else if (last_slot) begin
            slot_cnt <= '0;                 // next frame
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    // one clock per frame, timers step here
    assign o_frame_end = last_slot;

endmodule

// File: verilog/opm_bus.sv
module opm_bus
    import opm_pkg::*;
(
    input  logic      i_emuclk,
    input  logic      i_rst_n,

    // cpu bus
    input  logic      i_cs_n,
    input  logic      i_rd_n,
    input  logic      i_wr_n,
    input  logic      i_a0,
    input  bus_data_t i_d,
    output bus_data_t o_d,
    output logic      o_d_oe,

    // timer flags for status
    input  logic      i_flag_a,
    input  logic      i_flag_b,

    // write port to register block
    output logic      o_wr_strobe,
    output reg_addr_t o_wr_addr,
    output bus_data_t o_wr_data
);

    logic      bus_wr;
    logic      bus_rd;
    logic      data_wr;
    reg_addr_t addr_lat;    // address from the last a0=0 write
    busy_cnt_t busy_cnt;
    logic      busy;
    bus_data_t status;

    //////////////////////////////
    // decode

    assign bus_wr  = ~i_cs_n & ~i_wr_n;
    assign bus_rd  = ~i_cs_n & ~i_rd_n;
    assign data_wr = bus_wr & i_a0;

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            addr_lat    <= '0;
            o_wr_strobe <= 1'b0;
        end else begin
            if (bus_wr && !i_a0) begin
                addr_lat <= i_d;
            end
            o_wr_strobe <= data_wr;         // one clock per data write
        end
    end

    // payload follows the strobe
    always_ff @(posedge i_emuclk) begin
        o_wr_addr <= addr_lat;
        o_wr_data <= i_d;
    end

    //////////////////////////////
    // busy

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= busy_cnt_t'(BUSY_CYCLES);   // a new write restarts it
        end else if (busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = (busy_cnt != '0);

    //////////////////////////////
    // status read

    always_comb begin
        status              = '0;
        status[STAT_BUSY]   = busy;
        status[STAT_FLAG_A] = i_flag_a;
        status[STAT_FLAG_B] = i_flag_b;
    end

    // a0 is ignored, every read returns status
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_d_oe <= 1'b0;
        end else begin
            o_d_oe <= bus_rd;
        end
    end

    always_ff @(posedge i_emuclk) begin
        if (bus_rd) begin
            o_d <= status;
        end
    end

endmodule

// File: verilog/opm_reg.sv
module opm_reg
    import opm_pkg::*;
(
    input  logic      i_emuclk,
    input  logic      i_rst_n,

    // from bus decode
    input  logic      i_wr_strobe,
    input  reg_addr_t i_wr_addr,
    input  bus_data_t i_wr_data,

    // timer setup
    output timer_a_t  o_clka,
    output timer_b_t  o_clkb,
    output logic      o_load_a,
    output logic      o_load_b,
    output logic      o_irqen_a,
    output logic      o_irqen_b,
    output logic      o_flag_rst_a,
    output logic      o_flag_rst_b,

    // ct pins
    output logic      o_ct1,
    output logic      o_ct2
);

    bus_data_t  clka1;      // upper 8 bits of timer a
    logic [1:0] clka2;      // lower 2 bits

    assign o_clka = {clka1, clka2};

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            clka1        <= '0;
            clka2        <= '0;
            o_clkb       <= '0;
            o_load_a     <= 1'b0;
            o_load_b     <= 1'b0;
            o_irqen_a    <= 1'b0;
            o_irqen_b    <= 1'b0;
            o_flag_rst_a <= 1'b0;
            o_flag_rst_b <= 1'b0;
            o_ct1        <= 1'b0;
            o_ct2        <= 1'b0;
        end else begin
            // flag resets are strobes, never held
            o_flag_rst_a <= 1'b0;
            o_flag_rst_b <= 1'b0;

            if (i_wr_strobe) begin
                case (i_wr_addr)
                    ADDR_CLKA1: clka1 <= i_wr_data;
                    ADDR_CLKA2: clka2 <= i_wr_data[1:0];
                    ADDR_CLKB:  o_clkb <= i_wr_data;
                    ADDR_TIMER_CTRL: begin
                        o_load_a     <= i_wr_data[CTRL_LOAD_A];
                        o_load_b     <= i_wr_data[CTRL_LOAD_B];
                        o_irqen_a    <= i_wr_data[CTRL_IRQEN_A];
                        o_irqen_b    <= i_wr_data[CTRL_IRQEN_B];
                        o_flag_rst_a <= i_wr_data[CTRL_FRST_A];
                        o_flag_rst_b <= i_wr_data[CTRL_FRST_B];
                    end
                    ADDR_CT: begin
                        o_ct2 <= i_wr_data[7];
                        o_ct1 <= i_wr_data[6];
                    end
                    default: ;  // unmapped, dropped
                endcase
            end
        end
    end

endmodule

// File: verilog/opm_timer.sv
module opm_timer
    import opm_pkg::*;
(
    input  logic     i_emuclk,
    input  logic     i_rst_n,
    input  logic     i_frame_end,

    // setup from register block
    input  timer_a_t i_clka,
    input  timer_b_t i_clkb,
    input  logic     i_load_a,
    input  logic     i_load_b,
    input  logic     i_irqen_a,
    input  logic     i_irqen_b,
    input  logic     i_flag_rst_a,
    input  logic     i_flag_rst_b,

    output logic     o_flag_a,
    output logic     o_flag_b,
    output logic     o_irq_n
);

    logic     load_a_q, load_b_q;   // load bits one clock ago
    logic     pend_a, pend_b;       // load edge seen, waiting for frame end
    logic     rise_a, rise_b;
    logic     start_a, start_b;
    logic     ovfl_a, ovfl_b;
    logic     step_b;
    timer_a_t cnt_a;
    timer_b_t cnt_b;
    logic [$clog2(TIMER_B_PRESCALE)-1:0] pre_b;

    always_comb begin
        rise_a  = i_load_a & ~load_a_q;
        rise_b  = i_load_b & ~load_b_q;
        start_a = i_frame_end & (pend_a | rise_a);
        start_b = i_frame_end & (pend_b | rise_b);
        ovfl_a  = i_frame_end & ~start_a & i_load_a & (cnt_a == '1);
        step_b  = i_frame_end & ~start_b & i_load_b & (&pre_b);    // prescaler wraps
        ovfl_b  = step_b & (cnt_b == '1);
    end

    //////////////////////////////
    // load edge detect

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            load_a_q <= 1'b0;
            load_b_q <= 1'b0;
            pend_a   <= 1'b0;
            pend_b   <= 1'b0;
        end else begin
            load_a_q <= i_load_a;
            load_b_q <= i_load_b;
            if (start_a)     pend_a <= 1'b0;
            else if (rise_a) pend_a <= 1'b1;
            if (start_b)     pend_b <= 1'b0;
            else if (rise_b) pend_b <= 1'b1;
        end
    end

    //////////////////////////////
    // counters

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            cnt_a <= '0;
            cnt_b <= '0;
            pre_b <= '0;
        end else begin
            if (start_a) begin
                cnt_a <= i_clka;
            end else if (i_frame_end && i_load_a) begin
                cnt_a <= ovfl_a ? i_clka : cnt_a + 1'b1;   // reload at 1023
            end

            if (start_b) begin
                cnt_b <= i_clkb;
                pre_b <= '0;
            end else if (i_frame_end && i_load_b) begin
                pre_b <= pre_b + 1'b1;
                if (step_b) begin
                    cnt_b <= ovfl_b ? i_clkb : cnt_b + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // flags and irq

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_flag_a <= 1'b0;
            o_flag_b <= 1'b0;
            o_irq_n  <= 1'b1;
        end else begin
            if (i_flag_rst_a)              o_flag_a <= 1'b0;
            else if (ovfl_a && i_irqen_a)  o_flag_a <= 1'b1;
            if (i_flag_rst_b)              o_flag_b <= 1'b0;
            else if (ovfl_b && i_irqen_b)  o_flag_b <= 1'b1;
            o_irq_n <= ~(o_flag_a | o_flag_b);     // one clock behind the flags
        end
    end

endmodule

// File: verilog/opm_top.sv
module opm_top
    import opm_pkg::*;
(
    input  logic      i_emuclk,
    input  logic      i_rst_n,

    // cpu bus
    input  logic      i_cs_n,
    input  logic      i_rd_n,
    input  logic      i_wr_n,
    input  logic      i_a0,
    input  bus_data_t i_d,
    output bus_data_t o_d,
    output logic      o_d_oe,

    output logic      o_irq_n,
    output logic      o_ct1,
    output logic      o_ct2
);

    logic      frame_end;

    // bus to registers
    logic      wr_strobe;
    reg_addr_t wr_addr;
    bus_data_t wr_data;

    // registers to timers
    timer_a_t  clka;
    timer_b_t  clkb;
    logic      load_a, load_b;
    logic      irqen_a, irqen_b;
    logic      flag_rst_a, flag_rst_b;

    // timers back to status
    logic      flag_a, flag_b;

    //////////////////////////////
    // blocks

    opm_timing u_timing (
        .i_emuclk     (i_emuclk),
        .i_rst_n      (i_rst_n),
        .o_frame_end  (frame_end)
    );

    opm_bus u_bus (
        .i_emuclk     (i_emuclk),
        .i_rst_n      (i_rst_n),
        .i_cs_n       (i_cs_n),
        .i_rd_n       (i_rd_n),
        .i_wr_n       (i_wr_n),
        .i_a0         (i_a0),
        .i_d          (i_d),
        .o_d          (o_d),
        .o_d_oe       (o_d_oe),
        .i_flag_a     (flag_a),
        .i_flag_b     (flag_b),
        .o_wr_strobe  (wr_strobe),
        .o_wr_addr    (wr_addr),
        .o_wr_data    (wr_data)
    );

    opm_reg u_reg (
        .i_emuclk     (i_emuclk),
        .i_rst_n      (i_rst_n),
        .i_wr_strobe  (wr_strobe),
        .i_wr_addr    (wr_addr),
        .i_wr_data    (wr_data),
        .o_clka       (clka),
        .o_clkb       (clkb),
        .o_load_a     (load_a),
        .o_load_b     (load_b),
        .o_irqen_a    (irqen_a),
        .o_irqen_b    (irqen_b),
        .o_flag_rst_a (flag_rst_a),
        .o_flag_rst_b (flag_rst_b),
        .o_ct1        (o_ct1),
        .o_ct2        (o_ct2)
    );

    opm_timer u_timer (
        .i_emuclk     (i_emuclk),
        .i_rst_n      (i_rst_n),
        .i_frame_end  (frame_end),
        .i_clka       (clka),
        .i_clkb       (clkb),
        .i_load_a     (load_a),
        .i_load_b     (load_b),
        .i_irqen_a    (irqen_a),
        .i_irqen_b    (irqen_b),
        .i_flag_rst_a (flag_rst_a),
        .i_flag_rst_b (flag_rst_b),
        .o_flag_a     (flag_a),
        .o_flag_b     (flag_b),
        .o_irq_n      (o_irq_n)
    );

endmodule

// File: verif/opm_chk.sv
module opm_chk
    import opm_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_cs_n,
    input  logic i_rd_n,
    input  logic i_wr_n,
    input  logic i_a0,
    input  logic i_d_oe,
    input  logic i_flag_a,
    input  logic i_flag_b,
    input  logic i_irq_n,
    input  logic i_busy
);

    timeunit 1ns;
    timeprecision 1ps;

    logic rd_cyc;
    logic data_wr;
    int   busy_run;     // busy clocks since the last data write

    assign rd_cyc  = ~i_cs_n & ~i_rd_n;
    assign data_wr = ~i_cs_n & ~i_wr_n & i_a0;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || data_wr) begin
            busy_run <= 0;              // a data write restarts busy
        end else if (i_busy) begin
            busy_run <= busy_run + 1;
        end else begin
            busy_run <= 0;
        end
    end

    //////////////////////////////
    // bus and irq properties

    oe_after_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$past(rd_cyc) |-> !i_d_oe)
        else $error("o_d_oe high with no read in the previous cycle");

    irq_follows_flags: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_irq_n == !$past(i_flag_a | i_flag_b))
        else $error("o_irq_n does not follow the flags by one clock");

    busy_length: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_busy |-> busy_run < BUSY_CYCLES)
        else $error("busy held longer than the busy time");

endmodule

// File: verif/opm_tb.sv
module opm_tb
    import opm_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD     = 10;
    localparam int          RESET_CYCLES   = 3;
    localparam logic [15:0] LFSR_SEED      = 16'd12019;
    localparam logic [15:0] LFSR_TAPS      = 16'hB400;
    localparam int          TIMEOUT_MARGIN = 2000;

    localparam logic [1:0] ROW_FIXED     = 2'd0;
    localparam logic [1:0] ROW_RAND_CT   = 2'd1;   // random byte to the ct register
    localparam logic [1:0] ROW_RAND_ADDR = 2'd2;   // random byte to an unmapped address

    typedef struct packed {
        logic [1:0] kind;
        reg_addr_t  addr;
        bus_data_t  data;
        int         frames;
        logic [1:0] exp_flags;  // {b, a}
        logic       exp_irq_n;
        logic [1:0] exp_ct;     // {ct2, ct1}
    } row_t;

    logic      clk;
    logic      rst_n;
    logic      cs_n;
    logic      rd_n;
    logic      wr_n;
    logic      a0;
    bus_data_t d_in;
    bus_data_t d_out;
    logic      d_oe;
    logic      irq_n;
    logic      ct1;
    logic      ct2;

    row_t        rows[$];
    logic [15:0] lfsr;
    logic [1:0]  ct_exp;
    logic        row_failed;
    int          cycles;
    int          cycle_limit;
    int          error_count;
    int          test_count;
    int          fail_count;

    opm_top uut (
        .i_emuclk (clk),
        .i_rst_n  (rst_n),
        .i_cs_n   (cs_n),
        .i_rd_n   (rd_n),
        .i_wr_n   (wr_n),
        .i_a0     (a0),
        .i_d      (d_in),
        .o_d      (d_out),
        .o_d_oe   (d_oe),
        .o_irq_n  (irq_n),
        .o_ct1    (ct1),
        .o_ct2    (ct2)
    );

    bind opm_top opm_chk u_chk (
        .i_clk    (i_emuclk),
        .i_rst_n  (i_rst_n),
        .i_cs_n   (i_cs_n),
        .i_rd_n   (i_rd_n),
        .i_wr_n   (i_wr_n),
        .i_a0     (i_a0),
        .i_d_oe   (o_d_oe),
        .i_flag_a (flag_a),
        .i_flag_b (flag_b),
        .i_irq_n  (o_irq_n),
        .i_busy   (u_bus.busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    //////////////////////////////
    // helpers

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    task automatic draw_byte(output bus_data_t value);
        value = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr  = lfsr_next(lfsr);            // one step per bit
            value = {value[6:0], lfsr[0]};
        end
    endtask

    function automatic logic is_mapped(input reg_addr_t addr);
        return addr inside {ADDR_CLKA1, ADDR_CLKA2, ADDR_CLKB, ADDR_TIMER_CTRL, ADDR_CT};
    endfunction

    task automatic draw_unused_addr(output reg_addr_t addr);
        draw_byte(addr);
        while (is_mapped(addr)) begin
            draw_byte(addr);
        end
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
            error_count++;
            row_failed = 1'b1;
        end
    endtask

    task automatic bus_write(input logic a0_val, input bus_data_t value);
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        a0   <= a0_val;
        d_in <= value;
        @(posedge clk);                         // dut takes the write here
        cs_n <= 1'b1;
        wr_n <= 1'b1;
        @(negedge clk);
    endtask

    task automatic read_status(output bus_data_t status, output int rd_cycle);
        @(posedge clk);
        cs_n <= 1'b0;
        rd_n <= 1'b0;
        @(posedge clk);
        cs_n <= 1'b1;
        rd_n <= 1'b1;
        @(negedge clk);                         // o_d registered one clock after the read
        status   = d_out;
        rd_cycle = cycles;
        check_value("o_d_oe", 8'h01, 8'(d_oe));
        @(negedge clk);
        check_value("o_d_oe", 8'h00, 8'(d_oe));
    endtask

    task automatic wait_frames(input int frames);
        repeat (frames * SLOTS_PER_FRAME) @(posedge clk);
    endtask

    task automatic finish_test(input int idx, input string label);
        test_count++;
        if (row_failed) begin
            fail_count++;
        end
        $display("test %0d: %s: %s", idx, label, row_failed ? "failed" : "ok");
    endtask

    task automatic add_row(input logic [1:0] kind, input reg_addr_t addr,
                           input bus_data_t data, input int frames,
                           input logic [1:0] flags, input logic irq_n_exp,
                           input logic [1:0] ct);
        row_t r;
        r = '{kind, addr, data, frames, flags, irq_n_exp, ct};
        rows.push_back(r);
    endtask

    function automatic int total_frames();
        int sum;
        sum = 0;
        foreach (rows[i]) begin
            sum += rows[i].frames;
        end
        return sum;
    endfunction

    //////////////////////////////
    // stimulus table

    task automatic load_table();
        add_row(ROW_FIXED,     ADDR_CT,         8'hC0,  1, 2'b00, 1'b1, 2'b11);
        add_row(ROW_RAND_CT,   ADDR_CT,         8'h00,  0, 2'b00, 1'b1, 2'b00);
        add_row(ROW_RAND_CT,   ADDR_CT,         8'h00,  0, 2'b00, 1'b1, 2'b00);
        add_row(ROW_RAND_CT,   ADDR_CT,         8'h00,  1, 2'b00, 1'b1, 2'b00);
        add_row(ROW_RAND_ADDR, 8'h00,           8'h00,  0, 2'b00, 1'b1, 2'b00);
        add_row(ROW_RAND_ADDR, 8'h00,           8'h00,  1, 2'b00, 1'b1, 2'b00);
        add_row(ROW_FIXED,     ADDR_CT,         8'h00,  0, 2'b00, 1'b1, 2'b00);
        // timer a, 1020 gives a 4 frame period
        add_row(ROW_FIXED,     ADDR_CLKA1,      8'hFF,  0, 2'b00, 1'b1, 2'b00);
        add_row(ROW_FIXED,     ADDR_CLKA2,      8'h00,  0, 2'b00, 1'b1, 2'b00);
        add_row(ROW_FIXED,     ADDR_TIMER_CTRL, 8'h05,  2, 2'b00, 1'b1, 2'b00);
        add_row(ROW_RAND_ADDR, 8'h00,           8'h00,  3, 2'b01, 1'b0, 2'b00);
        add_row(ROW_FIXED,     ADDR_TIMER_CTRL, 8'h10,  0, 2'b00, 1'b1, 2'b00);
        // timer b, 254 gives a 32 frame period
        add_row(ROW_FIXED,     ADDR_CLKB,       8'hFE,  0, 2'b00, 1'b1, 2'b00);
        add_row(ROW_FIXED,     ADDR_TIMER_CTRL, 8'h0A, 29, 2'b00, 1'b1, 2'b00);
        add_row(ROW_RAND_ADDR, 8'h00,           8'h00,  6, 2'b10, 1'b0, 2'b00);
        add_row(ROW_FIXED,     ADDR_TIMER_CTRL, 8'h20,  0, 2'b00, 1'b1, 2'b00);
        // both timers running, irq enables clear
        add_row(ROW_FIXED,     ADDR_TIMER_CTRL, 8'h03, 40, 2'b00, 1'b1, 2'b00);
        add_row(ROW_FIXED,     ADDR_TIMER_CTRL, 8'h00,  1, 2'b00, 1'b1, 2'b00);
    endtask

    task automatic run_row(input int idx, input row_t row);
        reg_addr_t addr;
        bus_data_t data;
        bus_data_t status;
        bus_data_t exp_status;
        int        wr_cycle;
        int        rd_cycle;
        logic      busy_exp;
        addr = row.addr;
        data = row.data;
        if (row.kind == ROW_RAND_ADDR) begin
            draw_unused_addr(addr);
        end
        if (row.kind != ROW_FIXED) begin
            draw_byte(data);
        end
        if (row.kind == ROW_RAND_CT) begin
            ct_exp = data[7:6];                 // ct2 from bit 7, ct1 from bit 6
        end else if (row.kind == ROW_FIXED) begin
            ct_exp = row.exp_ct;
        end
        row_failed = 1'b0;
        bus_write(1'b0, addr);
        bus_write(1'b1, data);
        wr_cycle = cycles;
        @(negedge clk);                         // ct pins settle 2 clocks after the write
        check_value("o_ct2/o_ct1", 8'(ct_exp), 8'({ct2, ct1}));
        read_status(status, rd_cycle);
        busy_exp = (rd_cycle - wr_cycle) <= BUSY_CYCLES;
        check_value("status busy", 8'(busy_exp), 8'(status[STAT_BUSY]));
        wait_frames(row.frames);
        read_status(status, rd_cycle);
        busy_exp                = (rd_cycle - wr_cycle) <= BUSY_CYCLES;
        exp_status              = '0;
        exp_status[STAT_BUSY]   = busy_exp;
        exp_status[STAT_FLAG_A] = row.exp_flags[0];
        exp_status[STAT_FLAG_B] = row.exp_flags[1];
        check_value("status", exp_status, status);
        check_value("o_irq_n", 8'(row.exp_irq_n), 8'(irq_n));
        check_value("o_ct2/o_ct1", 8'(ct_exp), 8'({ct2, ct1}));
        finish_test(idx, $sformatf("write 0x%h <= 0x%h, wait %0d frames", addr, data,
                                   row.frames));
    endtask

    //////////////////////////////
    // main sequence

    initial begin
        bus_data_t status;
        int        rd_cycle;
        clk         = 1'b0;
        rst_n       = 1'b0;
        cs_n        = 1'b1;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        a0          = 1'b0;
        d_in        = '0;
        lfsr        = LFSR_SEED;
        ct_exp      = 2'b00;
        cycles      = 0;
        error_count = 0;
        test_count  = 0;
        fail_count  = 0;
        load_table();
        cycle_limit = total_frames() * SLOTS_PER_FRAME + TIMEOUT_MARGIN;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        row_failed = 1'b0;
        read_status(status, rd_cycle);
        check_value("status", 8'h00, status);
        check_value("o_irq_n", 8'h01, 8'(irq_n));
        check_value("o_ct2/o_ct1", 8'h00, 8'({ct2, ct1}));
        finish_test(0, "state after reset");

        foreach (rows[i]) begin
            run_row(i + 1, rows[i]);
        end

        $display("tests %0d, failed %0d, mismatches %0d", test_count, fail_count,
                 error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: project.f
verilog/opm_pkg.sv
verilog/opm_timing.sv
verilog/opm_bus.sv
verilog/opm_reg.sv
verilog/opm_timer.sv
verilog/opm_top.sv
verif/opm_chk.sv
verif/opm_tb.sv

// File: Makefile
TOP = opm_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP) -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f project.f --top-module $(TOP)
	verilator --lint-only --timescale 1ns/1ps \
		verilog/opm_pkg.sv verilog/opm_timing.sv verilog/opm_bus.sv \
		verilog/opm_reg.sv verilog/opm_timer.sv verilog/opm_top.sv \
		--top-module opm_top

clean:
	rm -rf obj_dir
